/* dv/scan_golden.txt */
# rnd htim vtim hwin vwin sl ctrl pix exp_inside exp_outside exp_scanline (hex)
# rnd=1 replaces pix and the three expected pixels with a seeded random pixel
0 02010018 0040400C 00010000 00004000 00000000 01800400 123456 123456 000000 123456
0 02010018 0040400C 00008004 00002002 00000000 0180056A 80C0F0 80C0F0 AA00AA 80C0F0
0 02010018 0040400C 00010000 00004000 00520030 01800400 205090 205090 000000 001151
0 02010018 0040400C 00008004 00002002 00640F00 01800496 FFFFFF FFFFFF 005500 000000
0 02010018 0040400C 00008004 00002002 00520030 01800497 777777 000000 000000 000000
1 02010018 0040400C 00008004 00002002 00520030 0180056A 000000 000000 000000 000000
0 04018028 00806014 0001400A 00003000 00000000 028007CE 0A0B0C 0A0B0C 333333 0A0B0C

/* compile.f */
+incdir+logic
logic/scan_pkg.sv
logic/scan_cfg_regs.sv
logic/scan_timing_gen.sv
logic/scan_pixel_pipe.sv
logic/scan_converter_top.sv
dv/scan_assertions.sv
dv/scan_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= scan_tb
MDIR      ?= obj_dir
FLIST     ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard logic/*.sv logic/*.svh dv/*.sv)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

run: $(BIN) dv/scan_golden.txt
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

/* dv/scan_tb.sv */
// Reads dv/scan_golden.txt from the project root; each vector uses one overlay bit at most
`timescale 1ns/1ps
`include "scan_defs.svh"

module scan_tb;

    logic                    clk;
    logic                    rst_n;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`SCAN_WB_AW-1:0]  adr;
    logic [`SCAN_WB_DW-1:0]  dat_w;
    logic [`SCAN_WB_DW-1:0]  dat_r;
    logic                    ack;
    scan_pkg::pixel_t        pix_in;
    scan_pkg::pixel_t        pix_out;
    logic                    hsync;
    logic                    vsync;
    logic                    de;
    logic [`SCAN_H_W-1:0]    xpos;
    logic [`SCAN_V_W-1:0]    ypos;

    logic [31:0]      vec [16][11];
    int               nvec;
    int               max_frame;
    int               seed;
    int               htot;
    int               hact;
    int               hsync_len;
    int               vtot;
    int               vact;
    int               vsync_len;
    int               xs;
    int               xsz;
    int               ys;
    int               ysz;
    int               interval;
    logic [3:0]       overlay;
    logic             sl_en;
    logic             tp_en;
    logic             mask_en;
    scan_pkg::pixel_t exp_in;
    scan_pkg::pixel_t exp_out;
    scan_pkg::pixel_t exp_sl;

    scan_converter_top uut (
        .PCLK_OUT_i (clk),
        .rst_n_i    (rst_n),
        .wb_cyc_i   (cyc),
        .wb_stb_i   (stb),
        .wb_we_i    (we),
        .wb_adr_i   (adr),
        .wb_dat_i   (dat_w),
        .pix_i      (pix_in),
        .wb_dat_o   (dat_r),
        .wb_ack_o   (ack),
        .pix_o      (pix_out),
        .hsync_o    (hsync),
        .vsync_o    (vsync),
        .de_o       (de),
        .xpos_o     (xpos),
        .ypos_o     (ypos)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_pixel(input string name, input scan_pkg::pixel_t got,
                               input scan_pkg::pixel_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [11];
        fd = $fopen("dv/scan_golden.txt", "r");
        if (fd == 0) stop_run("Could not open the golden vector file dv/scan_golden.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (n != 11) stop_run("A golden vector line does not hold eleven fields");
                for (int k = 0; k < 11; k++) vec[nvec][k] = f[k];
                if (int'(f[1][11:0]) * int'(f[2][10:0]) > max_frame) begin
                    max_frame = int'(f[1][11:0]) * int'(f[2][10:0]);
                end
                nvec++;
            end
        end
        $fclose(fd);
    endtask

    function automatic logic [7:0] darken_channel(input logic [7:0] c, input int s);
        return (int'(c) <= s) ? 8'h00 : 8'(int'(c) - s);
    endfunction

    // Derive the expected pixels for a random vector from the mask and scanline rules
    task automatic build_random(input int i);
        scan_pkg::pixel_t p;
        logic [7:0]       lvl;
        logic [3:0]       nib;
        int               k;
        int               s;
        p = 24'($random(seed));
        lvl = {2{vec[i][6][5:2]}};
        k = 0;
        while (k < 3 && !vec[i][5][16 + k]) k++;
        nib = vec[i][5][4 * k +: 4];
        s = (int'(nib) + 1) * 16 - 1;
        vec[i][7]  = {8'h00, p};
        vec[i][8]  = {8'h00, p};
        vec[i][9]  = {8'h00, vec[i][6][8] ? lvl : 8'h00, vec[i][6][7] ? lvl : 8'h00,
                      vec[i][6][6] ? lvl : 8'h00};
        vec[i][10] = {8'h00, darken_channel(p.r, s), darken_channel(p.g, s),
                      darken_channel(p.b, s)};
    endtask

    task automatic decode_vector(input int i);
        htot      = int'(vec[i][1][11:0]);
        hact      = int'(vec[i][1][23:12]);
        hsync_len = int'(vec[i][1][31:24]);
        vtot      = int'(vec[i][2][10:0]);
        vact      = int'(vec[i][2][21:11]);
        vsync_len = int'(vec[i][2][31:22]);
        xs        = int'(vec[i][3][11:0]);
        xsz       = int'(vec[i][3][23:12]);
        ys        = int'(vec[i][4][10:0]);
        ysz       = int'(vec[i][4][21:11]);
        overlay   = vec[i][5][19:16];
        interval  = int'(vec[i][5][21:20]);
        sl_en     = vec[i][5][22];
        tp_en     = vec[i][6][0];
        mask_en   = vec[i][6][1];
        exp_in    = vec[i][8][23:0];
        exp_out   = vec[i][9][23:0];
        exp_sl    = vec[i][10][23:0];
    endtask

    task automatic wb_access(input logic wr, input logic [2:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_w = d;
        do @(negedge clk); while (!ack);
        rd = dat_r;
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        do begin
            prev = vsync;
            @(negedge clk);
        end while (!(prev && !vsync));
    endtask

    function automatic scan_pkg::pixel_t expected_pixel(input int x, input int y);
        logic [7:0] t;
        logic       in_win;
        t = 8'(x ^ y);
        in_win = (x >= xs) && (x < xs + xsz) && (y >= ys) && (y < ys + ysz);
        if (tp_en) return {t, t, t};
        if (mask_en && !in_win) return exp_out;
        if (sl_en && overlay[y % (interval + 1)]) return exp_sl;
        return exp_in;
    endfunction

    // One frame from the VSYNC falling edge, sampled on the falling clock edge
    task automatic check_frame();
        int hs_run;
        int de_run;
        int de_lines;
        int vs_cycles;
        hs_run = 0;
        de_run = 0;
        de_lines = 0;
        vs_cycles = 0;
        wait_vsync_fall();
        for (int c = 0; c < htot * vtot; c++) begin
            if (c > 0) @(negedge clk);
            if (!vsync) vs_cycles++;
            if (!hsync) begin
                hs_run++;
            end else if (hs_run > 0) begin
                check_count("hsync low cycles", hs_run, hsync_len);
                hs_run = 0;
            end
            if (de) begin
                check_count("xpos", int'(xpos), de_run);
                check_count("ypos", int'(ypos), de_lines);
                check_pixel("pixel", pix_out, expected_pixel(de_run, de_lines));
                de_run++;
            end else if (de_run > 0) begin
                check_count("de cycles per line", de_run, hact);
                de_lines++;
                de_run = 0;
            end
        end
        check_count("de lines per frame", de_lines, vact);
        check_count("vsync low cycles", vs_cycles, vsync_len * htot);
    endtask

    initial begin : watchdog
        longint limit;
        #1;
        // Four frame lengths per vector cover the settling frames and the checked frame
        limit = longint'(nvec) * 4 * longint'(max_frame) * 10 + 20000;
        #(limit);
        $display("Timeout: the test did not finish within %0d ns", limit);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main
        logic [31:0] rd;
        clk = 1'b0;
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        pix_in = '0;
        nvec = 0;
        max_frame = 0;
        seed = 32'head490c1;
        load_golden();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < nvec; i++) begin
            if (vec[i][0] != 0) build_random(i);
            decode_vector(i);
            for (int r = 0; r < `SCAN_REG_NUM; r++) begin
                wb_access(1'b1, 3'(r), vec[i][r + 1], rd);
            end
            // Address 6 is unmapped, so this write must leave every register unchanged
            wb_access(1'b1, 3'd6, 32'hFFFF_FFFF, rd);
            pix_in = vec[i][7][23:0];
            for (int r = 0; r < `SCAN_REG_NUM; r++) begin
                wb_access(1'b0, 3'(r), '0, rd);
                check_word("register readback", rd, vec[i][r + 1]);
            end
            wb_access(1'b0, 3'd6, '0, rd);
            check_word("unmapped readback", rd, 32'h0);
            wait_vsync_fall();
            wait_vsync_fall();
            check_frame();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* dv/scan_assertions.sv */
// Bus and sync rules only; pixel values are checked by the testbench itself
`timescale 1ns/1ps

module scan_assertions (
    input logic PCLK_OUT_i,
    input logic rst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic hsync_o,
    input logic vsync_o,
    input logic de_o
);

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge PCLK_OUT_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o stayed high for more than one cycle");

    // Ack only answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge PCLK_OUT_i) disable iff (!rst_n_i)
        $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o rose without a bus request");

    // A new request is acknowledged on the very next edge
    req_gets_ack: assert property (@(posedge PCLK_OUT_i) disable iff (!rst_n_i)
        (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
        else $error("wb_ack_o did not follow a bus request after one cycle");

    // DE never overlaps either sync pulse
    de_outside_sync: assert property (@(posedge PCLK_OUT_i) disable iff (!rst_n_i)
        de_o |-> (hsync_o && vsync_o))
        else $error("DE high during a sync pulse");

    // A frame starts on a line start, so HSYNC is low when VSYNC falls
    vsync_on_line_start: assert property (@(posedge PCLK_OUT_i) disable iff (!rst_n_i)
        $fell(vsync_o) |-> !hsync_o)
        else $error("VSYNC fell away from a line start");

endmodule

bind scan_converter_top scan_assertions u_assertions (.*);

/* logic/scan_converter_top.sv */
// Outputs trail the internal counters by a fixed 6 cycles; pix_i has no valid strobe
`timescale 1ns/1ps
`include "scan_defs.svh"

module scan_converter_top (
    input  logic                   PCLK_OUT_i,
    input  logic                   rst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`SCAN_WB_AW-1:0] wb_adr_i,
    input  logic [`SCAN_WB_DW-1:0] wb_dat_i,
    input  scan_pkg::pixel_t       pix_i,
    output logic [`SCAN_WB_DW-1:0] wb_dat_o,
    output logic                   wb_ack_o,
    output scan_pkg::pixel_t       pix_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   de_o,
    output logic [`SCAN_H_W-1:0]   xpos_o,
    output logic [`SCAN_V_W-1:0]   ypos_o
);

    scan_pkg::h_timing_t     h_cfg;
    scan_pkg::v_timing_t     v_cfg;
    scan_pkg::window_t       win_cfg;
    scan_pkg::scanline_cfg_t sl_cfg;
    scan_pkg::ctrl_cfg_t     ctrl_cfg;

    // Stage 1 timing, straight from the counters
    logic                    tg_hsync;
    logic                    tg_vsync;
    logic                    tg_de;
    logic [`SCAN_H_W-1:0]    tg_xpos;
    logic [`SCAN_V_W-1:0]    tg_ypos;
    logic [1:0]              tg_sl_line;

    scan_cfg_regs u_cfg_regs (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .h_cfg_o    (h_cfg),
        .v_cfg_o    (v_cfg),
        .win_cfg_o  (win_cfg),
        .sl_cfg_o   (sl_cfg),
        .ctrl_cfg_o (ctrl_cfg)
    );

    scan_timing_gen u_timing_gen (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .h_cfg_i    (h_cfg),
        .v_cfg_i    (v_cfg),
        .sl_cfg_i   (sl_cfg),
        .hsync_o    (tg_hsync),
        .vsync_o    (tg_vsync),
        .de_o       (tg_de),
        .xpos_o     (tg_xpos),
        .ypos_o     (tg_ypos),
        .sl_line_o  (tg_sl_line)
    );

    scan_pixel_pipe u_pixel_pipe (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .hsync_i    (tg_hsync),
        .vsync_i    (tg_vsync),
        .de_i       (tg_de),
        .xpos_i     (tg_xpos),
        .ypos_i     (tg_ypos),
        .sl_line_i  (tg_sl_line),
        .pix_i      (pix_i),
        .win_cfg_i  (win_cfg),
        .sl_cfg_i   (sl_cfg),
        .ctrl_cfg_i (ctrl_cfg),
        .pix_o      (pix_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .de_o       (de_o),
        .xpos_o     (xpos_o),
        .ypos_o     (ypos_o)
    );

endmodule

/* logic/scan_pixel_pipe.sv */
// Never stalls; pix_i is sampled every cycle in stage 3 and must line up with that stage's position
`timescale 1ns/1ps
`include "scan_defs.svh"

module scan_pixel_pipe (
    input  logic                    PCLK_OUT_i,
    input  logic                    rst_n_i,
    input  logic                    hsync_i,
    input  logic                    vsync_i,
    input  logic                    de_i,
    input  logic [`SCAN_H_W-1:0]    xpos_i,
    input  logic [`SCAN_V_W-1:0]    ypos_i,
    input  logic [1:0]              sl_line_i,
    input  scan_pkg::pixel_t        pix_i,
    input  scan_pkg::window_t       win_cfg_i,
    input  scan_pkg::scanline_cfg_t sl_cfg_i,
    input  scan_pkg::ctrl_cfg_t     ctrl_cfg_i,
    output scan_pkg::pixel_t        pix_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    de_o,
    output logic [`SCAN_H_W-1:0]    xpos_o,
    output logic [`SCAN_V_W-1:0]    ypos_o
);

    localparam int CW      = `SCAN_COLOR_W;
    localparam int S_MASK  = `SCAN_PP_MASK;
    localparam int S_SRC   = `SCAN_PP_SRC;
    localparam int S_SLSEL = `SCAN_PP_SLSEL;
    localparam int S_SLSUB = `SCAN_PP_SLSUB;
    localparam int S_OUT   = `SCAN_PP_LATENCY;

    logic                 hs_pp   [S_MASK:S_OUT];
    logic                 vs_pp   [S_MASK:S_OUT];
    logic                 de_pp   [S_MASK:S_OUT];
    logic [`SCAN_H_W-1:0] xpos_pp [S_MASK:S_OUT];
    logic [`SCAN_V_W-1:0] ypos_pp [S_MASK:S_OUT];
    logic                 mask_pp [S_MASK:S_SLSUB];
    logic [1:0]           sl_line_pp [S_MASK:S_SRC];
    scan_pkg::pixel_t     pix_pp  [S_SRC:S_OUT];
    logic                 draw_sl;
    logic [CW-1:0]        sl_str;
    logic                 in_win;
    logic [CW-1:0]        mask_lvl;
    logic [CW-1:0]        tp_val;

    function automatic logic [CW-1:0] sat_sub(input logic [CW-1:0] a, input logic [CW-1:0] b);
        return (a > b) ? (a - b) : '0;
    endfunction

    // Sizes are added with a carry bit so a window at the far edge does not wrap
    assign in_win = (xpos_i >= win_cfg_i.x_start) &
                    ({1'b0, xpos_i} < {1'b0, win_cfg_i.x_start} + {1'b0, win_cfg_i.x_size}) &
                    (ypos_i >= win_cfg_i.y_start) &
                    ({1'b0, ypos_i} < {1'b0, win_cfg_i.y_start} + {1'b0, win_cfg_i.y_size});

    assign mask_lvl = {2{ctrl_cfg_i.mask_br}};
    assign tp_val   = xpos_pp[S_SLSUB][CW-1:0] ^ ypos_pp[S_SLSUB][CW-1:0];

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = S_MASK; i <= S_OUT; i++) begin
                hs_pp[i] <= 1'b1;
                vs_pp[i] <= 1'b1;
                de_pp[i] <= 1'b0;
            end
            for (int i = S_MASK; i <= S_SLSUB; i++) begin
                mask_pp[i] <= 1'b0;
            end
            draw_sl <= 1'b0;
        end else begin
            hs_pp[S_MASK]   <= hsync_i;
            vs_pp[S_MASK]   <= vsync_i;
            de_pp[S_MASK]   <= de_i;
            mask_pp[S_MASK] <= ctrl_cfg_i.mask_en & ~in_win;
            for (int i = S_MASK + 1; i <= S_OUT; i++) begin
                hs_pp[i] <= hs_pp[i-1];
                vs_pp[i] <= vs_pp[i-1];
                de_pp[i] <= de_pp[i-1];
            end
            for (int i = S_MASK + 1; i <= S_SLSUB; i++) begin
                mask_pp[i] <= mask_pp[i-1];
            end
            draw_sl <= sl_cfg_i.enable & sl_cfg_i.overlay[sl_line_pp[S_SRC]];
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        xpos_pp[S_MASK]    <= xpos_i;
        ypos_pp[S_MASK]    <= ypos_i;
        sl_line_pp[S_MASK] <= sl_line_i;
        for (int i = S_MASK + 1; i <= S_OUT; i++) begin
            xpos_pp[i] <= xpos_pp[i-1];
            ypos_pp[i] <= ypos_pp[i-1];
        end
        sl_line_pp[S_SRC] <= sl_line_pp[S_MASK];

        pix_pp[S_SRC] <= pix_i;

        // Strength nibble s becomes (s+1)*16-1, so 0 is a faint line and 15 is full black
        pix_pp[S_SLSEL] <= pix_pp[S_SRC];
        sl_str <= ((CW'(sl_cfg_i.str[sl_line_pp[S_SRC]]) + CW'(1)) << `SCAN_SL_SHIFT) - CW'(1);

        pix_pp[S_SLSUB].r <= draw_sl ? sat_sub(pix_pp[S_SLSEL].r, sl_str) : pix_pp[S_SLSEL].r;
        pix_pp[S_SLSUB].g <= draw_sl ? sat_sub(pix_pp[S_SLSEL].g, sl_str) : pix_pp[S_SLSEL].g;
        pix_pp[S_SLSUB].b <= draw_sl ? sat_sub(pix_pp[S_SLSEL].b, sl_str) : pix_pp[S_SLSEL].b;

        // Test pattern overrides the mask, which overrides the processed pixel
        if (ctrl_cfg_i.testpattern_en) begin
            pix_pp[S_OUT] <= {tp_val, tp_val, tp_val};
        end else if (mask_pp[S_SLSUB]) begin
            pix_pp[S_OUT].r <= ctrl_cfg_i.mask_color[2] ? mask_lvl : '0;
            pix_pp[S_OUT].g <= ctrl_cfg_i.mask_color[1] ? mask_lvl : '0;
            pix_pp[S_OUT].b <= ctrl_cfg_i.mask_color[0] ? mask_lvl : '0;
        end else begin
            pix_pp[S_OUT] <= pix_pp[S_SLSUB];
        end
    end

    assign pix_o   = pix_pp[S_OUT];
    assign hsync_o = hs_pp[S_OUT];
    assign vsync_o = vs_pp[S_OUT];
    assign de_o    = de_pp[S_OUT];
    assign xpos_o  = xpos_pp[S_OUT];
    assign ypos_o  = ypos_pp[S_OUT];

endmodule

/* logic/scan_timing_gen.sv */
// Free-running progressive timing; sync+backporch+active must fit inside total or DE never drops
`timescale 1ns/1ps
`include "scan_defs.svh"

module scan_timing_gen (
    input  logic                    PCLK_OUT_i,
    input  logic                    rst_n_i,
    input  scan_pkg::h_timing_t     h_cfg_i,
    input  scan_pkg::v_timing_t     v_cfg_i,
    input  scan_pkg::scanline_cfg_t sl_cfg_i,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    de_o,
    output logic [`SCAN_H_W-1:0]    xpos_o,
    output logic [`SCAN_V_W-1:0]    ypos_o,
    output logic [1:0]              sl_line_o
);

    localparam int HW = `SCAN_H_W;
    localparam int VW = `SCAN_V_W;

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic [HW-1:0] h_start;
    logic [HW-1:0] h_end;
    logic [VW-1:0] v_start;
    logic [VW-1:0] v_end;
    logic          h_act;
    logic          v_act;
    logic          line_start;
    logic [1:0]    sl_cnt;
    logic [1:0]    sl_next;

    // First active pixel/line and the first position past the active area
    assign h_start = HW'(h_cfg_i.synclen) + h_cfg_i.backporch;
    assign h_end   = h_start + h_cfg_i.active;
    assign v_start = VW'(v_cfg_i.synclen) + VW'(v_cfg_i.backporch);
    assign v_end   = v_start + v_cfg_i.active;

    assign h_act = (h_cnt >= h_start) & (h_cnt < h_end);
    assign v_act = (v_cnt >= v_start) & (v_cnt < v_end);

    assign line_start = (h_cnt == h_start) & v_act;

    // The scanline phase restarts on the first active line of every frame
    always_comb begin
        if ((v_cnt == v_start) || (sl_cnt == sl_cfg_i.interval)) begin
            sl_next = 2'd0;
        end else begin
            sl_next = sl_cnt + 2'd1;
        end
    end

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_cfg_i.total - HW'(1)) begin
            h_cnt <= '0;
            if (v_cnt == v_cfg_i.total - VW'(1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + VW'(1);
            end
        end else begin
            h_cnt <= h_cnt + HW'(1);
        end
    end

    // Stage 1 outputs, all derived from the same counter state
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hsync_o   <= 1'b1;
            vsync_o   <= 1'b1;
            de_o      <= 1'b0;
            xpos_o    <= '0;
            ypos_o    <= '0;
            sl_cnt    <= '0;
            sl_line_o <= '0;
        end else begin
            hsync_o <= ~(h_cnt < HW'(h_cfg_i.synclen));
            vsync_o <= ~(v_cnt < VW'(v_cfg_i.synclen));
            de_o    <= h_act & v_act;
            // Positions wrap outside the active area, only DE qualifies them
            xpos_o  <= h_cnt - h_start;
            ypos_o  <= v_cnt - v_start;
            if (line_start) begin
                sl_cnt    <= sl_next;
                sl_line_o <= sl_next;
            end else begin
                sl_line_o <= sl_cnt;
            end
        end
    end

endmodule

/* logic/scan_cfg_regs.sv */
// Wishbone classic slave with a fixed one-cycle ack; addresses 6 and 7 read zero and drop writes
`timescale 1ns/1ps
`include "scan_defs.svh"

module scan_cfg_regs (
    input  logic                        PCLK_OUT_i,
    input  logic                        rst_n_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`SCAN_WB_AW-1:0]      wb_adr_i,
    input  logic [`SCAN_WB_DW-1:0]      wb_dat_i,
    output logic [`SCAN_WB_DW-1:0]      wb_dat_o,
    output logic                        wb_ack_o,
    output scan_pkg::h_timing_t         h_cfg_o,
    output scan_pkg::v_timing_t         v_cfg_o,
    output scan_pkg::window_t           win_cfg_o,
    output scan_pkg::scanline_cfg_t     sl_cfg_o,
    output scan_pkg::ctrl_cfg_t         ctrl_cfg_o
);

    logic [`SCAN_WB_DW-1:0] regs [`SCAN_REG_NUM];
    logic                   bus_req;
    logic                   adr_hit;

    // A new request is taken only while ack is low, so each access acks once
    assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign adr_hit = (wb_adr_i < `SCAN_WB_AW'(`SCAN_REG_NUM));

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            regs[`SCAN_REG_HTIM] <= `SCAN_DEF_HTIM;
            regs[`SCAN_REG_VTIM] <= `SCAN_DEF_VTIM;
            regs[`SCAN_REG_HWIN] <= `SCAN_DEF_HWIN;
            regs[`SCAN_REG_VWIN] <= `SCAN_DEF_VWIN;
            regs[`SCAN_REG_SL]   <= `SCAN_DEF_SL;
            regs[`SCAN_REG_CTRL] <= `SCAN_DEF_CTRL;
        end else begin
            wb_ack_o <= bus_req;
            if (bus_req & wb_we_i & adr_hit) begin
                regs[wb_adr_i] <= wb_dat_i;
            end
        end
    end

    // Read data is captured on the edge that raises ack and held for that cycle
    always_ff @(posedge PCLK_OUT_i) begin
        if (bus_req) begin
            wb_dat_o <= adr_hit ? regs[wb_adr_i] : '0;
        end
    end

    // Unpack register fields, see the map in scan_defs.svh
    always_comb begin
        h_cfg_o.total     = regs[`SCAN_REG_HTIM][11:0];
        h_cfg_o.active    = regs[`SCAN_REG_HTIM][23:12];
        h_cfg_o.synclen   = regs[`SCAN_REG_HTIM][31:24];
        h_cfg_o.backporch = {3'b000, regs[`SCAN_REG_CTRL][31:23]};

        v_cfg_o.total     = regs[`SCAN_REG_VTIM][10:0];
        v_cfg_o.active    = regs[`SCAN_REG_VTIM][21:11];
        v_cfg_o.synclen   = regs[`SCAN_REG_VTIM][31:22];
        v_cfg_o.backporch = regs[`SCAN_REG_CTRL][18:9];

        win_cfg_o.x_start = regs[`SCAN_REG_HWIN][11:0];
        win_cfg_o.x_size  = regs[`SCAN_REG_HWIN][23:12];
        win_cfg_o.y_start = regs[`SCAN_REG_VWIN][10:0];
        win_cfg_o.y_size  = regs[`SCAN_REG_VWIN][21:11];

        sl_cfg_o.str      = regs[`SCAN_REG_SL][15:0];
        sl_cfg_o.overlay  = regs[`SCAN_REG_SL][19:16];
        sl_cfg_o.interval = regs[`SCAN_REG_SL][21:20];
        sl_cfg_o.enable   = regs[`SCAN_REG_SL][22];

        ctrl_cfg_o.testpattern_en = regs[`SCAN_REG_CTRL][0];
        ctrl_cfg_o.mask_en        = regs[`SCAN_REG_CTRL][1];
        ctrl_cfg_o.mask_br        = regs[`SCAN_REG_CTRL][5:2];
        ctrl_cfg_o.mask_color     = regs[`SCAN_REG_CTRL][8:6];
    end

endmodule

/* logic/scan_pkg.sv */
// Field widths follow scan_defs.svh; H backporch is wider than its 9-bit register field
`include "scan_defs.svh"

package scan_pkg;

    typedef struct packed {
        logic [`SCAN_COLOR_W-1:0] r;
        logic [`SCAN_COLOR_W-1:0] g;
        logic [`SCAN_COLOR_W-1:0] b;
    } pixel_t;

    // Horizontal timing, backporch comes from the control register
    typedef struct packed {
        logic [`SCAN_H_W-1:0]      total;
        logic [`SCAN_H_W-1:0]      active;
        logic [`SCAN_H_SYNC_W-1:0] synclen;
        logic [`SCAN_H_W-1:0]      backporch;
    } h_timing_t;

    typedef struct packed {
        logic [`SCAN_V_W-1:0]      total;
        logic [`SCAN_V_W-1:0]      active;
        logic [`SCAN_V_SYNC_W-1:0] synclen;
        logic [`SCAN_V_BP_W-1:0]   backporch;
    } v_timing_t;

    // Window is unsigned and relative to the first active pixel and line
    typedef struct packed {
        logic [`SCAN_H_W-1:0] x_start;
        logic [`SCAN_H_W-1:0] x_size;
        logic [`SCAN_V_W-1:0] y_start;
        logic [`SCAN_V_W-1:0] y_size;
    } window_t;

    typedef struct packed {
        logic [3:0][3:0] str;
        logic [3:0]      overlay;
        logic [1:0]      interval;
        logic            enable;
    } scanline_cfg_t;

    typedef struct packed {
        logic       testpattern_en;
        logic       mask_en;
        logic [3:0] mask_br;
        logic [2:0] mask_color;
    } ctrl_cfg_t;

endpackage

/* logic/scan_defs.svh */
// Register map and widths are fixed at build time; the register defaults assume a 16x8 active test mode
`ifndef SCAN_DEFS_SVH
`define SCAN_DEFS_SVH

// Counter and data widths
`define SCAN_H_W        12
`define SCAN_V_W        11
`define SCAN_COLOR_W    8
`define SCAN_H_SYNC_W   8
`define SCAN_V_SYNC_W   10
`define SCAN_V_BP_W     10

// Wishbone slave geometry
`define SCAN_WB_AW      3
`define SCAN_WB_DW      32

// Register word addresses and bit fields
// HTIM  [11:0] H total, [23:12] H active, [31:24] H sync length
// VTIM  [10:0] V total, [21:11] V active, [31:22] V sync length
// HWIN  [11:0] X start, [23:12] X size
// VWIN  [10:0] Y start, [21:11] Y size
// SL    [15:0] line strengths (line 0 in [3:0]), [19:16] overlay, [21:20] interval, [22] enable
// CTRL  [0] test pattern, [1] mask enable, [5:2] mask brightness, [8:6] mask colour (R,G,B)
// CTRL  [18:9] V backporch, [31:23] H backporch
`define SCAN_REG_HTIM   3'd0
`define SCAN_REG_VTIM   3'd1
`define SCAN_REG_HWIN   3'd2
`define SCAN_REG_VWIN   3'd3
`define SCAN_REG_SL     3'd4
`define SCAN_REG_CTRL   3'd5
`define SCAN_REG_NUM    6

// Reset mode: 24x12 total, 16x8 active, full-frame window, no post-processing
`define SCAN_DEF_HTIM   32'h0201_0018
`define SCAN_DEF_VTIM   32'h0040_400C
`define SCAN_DEF_HWIN   32'h0001_0000
`define SCAN_DEF_VWIN   32'h0000_4000
`define SCAN_DEF_SL     32'h0000_0000
`define SCAN_DEF_CTRL   32'h0180_0400

// Pipeline stage numbers, stage 1 is the registered timing generator output
`define SCAN_PP_SYNC    1
`define SCAN_PP_MASK    2
`define SCAN_PP_SRC     3
`define SCAN_PP_SLSEL   4
`define SCAN_PP_SLSUB   5
`define SCAN_PP_LATENCY 6

// Scanline strength nibble expands to (s+1)*16-1
`define SCAN_SL_SHIFT   4

`endif
